// ==== Makefile ====
# Verilator build and run of the PMA unit testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_pma_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_pma_top.sv ====
// tb_pma_top: clock, reset, LCG stimulus, reference model and checking assertions
`timescale 1ns/10ps
`default_nettype none

`include "pma_consts.svh"

module tb_pma_top
  import pma_cfg_pkg::*, pma_status_pkg::*;
();

  // the five tests take roughly 1500 cycles
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int RANDOM_XFERS   = 500;

  logic        clk;
  logic        rst_i;
  logic        cfg_we_i;
  region_idx_t cfg_idx_i;
  cfg_field_t  cfg_field_i;
  addr_t       cfg_wdata_i;
  logic        trans_valid_i;
  logic        trans_ready_o;
  addr_t       trans_addr_i;
  logic [1:0]  trans_size_i;
  logic        trans_load_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  logic        resp_fault_o;
  pma_attr_t   resp_attr_o;
  logic        resp_override_dm_o;
  region_idx_t resp_region_o;
  logic        resp_have_match_o;
  pma_cnt_t    cnt_access_o;
  pma_cnt_t    cnt_no_match_o;
  pma_cnt_t    cnt_multi_match_o;
  pma_cnt_t    cnt_misaligned_o;
  pma_cnt_t    cnt_load_o;

  // reference copy of the region table
  addr_t       mdl_base [`PMA_NUM_REGIONS];
  addr_t       mdl_mask [`PMA_NUM_REGIONS];
  pma_attr_t   mdl_attr [`PMA_NUM_REGIONS];

  // expected responses in acceptance order
  // packed as {fault, attr, override_dm, region, have_match}
  logic [8:0]  exp_q [$];
  logic [8:0]  exp_head = '0;
  logic        exp_pending = 1'b0;
  logic        exp_fault;
  pma_attr_t   exp_attr;
  logic        exp_dm;
  region_idx_t exp_region;
  logic        exp_have;

  // model event counts, one per DUT counter
  int mdl_access;
  int mdl_no_match;
  int mdl_multi;
  int mdl_misaligned;
  int mdl_load;
  int resp_seen;

  logic [31:0] lcg_state = 32'd7;
  logic        stall_on = 1'b0;
  int          cycles = 0;
  int          errors = 0;
  int          xfers = 0;
  int          mark_errors = 0;
  int          mark_xfers = 0;

  pma_top #(.IS_INSTR_SIDE(1'b0)) u_dut (.*);

  always #10 clk = ~clk;

  assign exp_fault  = exp_head[8];
  assign exp_attr   = exp_head[7:4];
  assign exp_dm     = exp_head[3];
  assign exp_region = exp_head[2:1];
  assign exp_have   = exp_head[0];

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // low LCG bits cycle fast, so draw from the middle
  function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  // entry hit when the address differs from the base only outside the mask
  function automatic logic region_hits(input addr_t a, input int r);
    return ((a ^ mdl_base[r]) & mdl_mask[r]) == '0;
  endfunction

  // address not a multiple of the access size
  function automatic logic is_misaligned(input addr_t a, input logic [1:0] sz);
    return (sz == 2'd1 && a[0]) || (sz == 2'd2 && a[1:0] != 2'b00);
  endfunction

  function automatic int count_hits(input addr_t a);
    int n;
    n = 0;
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      if (region_hits(a, r)) n++;
    end
    return n;
  endfunction

  // first hit in index order decides
  // debug window is main regardless of the table
  function automatic logic [8:0] predict(input addr_t a, input logic [1:0] sz);
    logic        hit;
    region_idx_t idx;
    pma_attr_t   at;
    logic        dm;
    logic        flt;
    hit = 1'b0;
    idx = '0;
    at  = '0;
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      if (!hit && region_hits(a, r)) begin
        hit = 1'b1;
        idx = region_idx_t'(r);
        at  = mdl_attr[r];
      end
    end
    dm = ((a ^ `PMA_DM_BASE) & `PMA_DM_MASK) == '0;
    if (dm) at[ATTR_MAIN] = 1'b1;
    flt = !at[ATTR_MAIN] || (is_misaligned(a, sz) && at[ATTR_INTEGRITY]);
    return {flt, at, dm, idx, hit};
  endfunction

  // mix of nested regions, the debug window and anywhere
  function automatic addr_t pick_addr();
    logic [31:0] v;
    v = lcg_next();
    case (rand_below(6))
      0: return 32'h8000_0000 | (v & 32'h0000_0FFF);
      1: return 32'h8000_0000 | (v & 32'h0000_FFFF);
      2: return 32'h8000_0000 | (v & 32'h0FFF_FFFF);
      3: return 32'h2000_0000 | (v & 32'h0FFF_FFFF);
      4: return `PMA_DM_BASE | (v & ~`PMA_DM_MASK);
      default: return v;
    endcase
  endfunction

  // reference model on the same edge the DUT registers on
  always @(posedge clk) begin
    logic [8:0] p;
    if (rst_i) begin
      for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
        mdl_base[r] = '0;
        mdl_mask[r] = '1;
        mdl_attr[r] = '0;
      end
      exp_q.delete();
      mdl_access     = 0;
      mdl_no_match   = 0;
      mdl_multi      = 0;
      mdl_misaligned = 0;
      mdl_load       = 0;
      resp_seen      = 0;
    end else begin
      // the response leaving now is older than anything accepted now
      if (resp_valid_o && resp_ready_i && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        resp_seen++;
      end
      if (trans_valid_i && trans_ready_o) begin
        p = predict(trans_addr_i, trans_size_i);
        exp_q.push_back(p);
        mdl_access++;
        if (!p[0]) mdl_no_match++;
        if (count_hits(trans_addr_i) >= 2) mdl_multi++;
        if (is_misaligned(trans_addr_i, trans_size_i)) mdl_misaligned++;
        if (trans_load_i) mdl_load++;
      end
      // table writes apply to transfers from the next cycle
      if (cfg_we_i) begin
        case (cfg_field_i)
          2'd0: mdl_base[cfg_idx_i] = cfg_wdata_i;
          2'd1: mdl_mask[cfg_idx_i] = cfg_wdata_i;
          2'd2: mdl_attr[cfg_idx_i] = cfg_wdata_i[3:0];
          default: ;
        endcase
      end
    end
    exp_pending = exp_q.size() > 0;
    exp_head    = exp_pending ? exp_q[0] : '0;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    errors++;
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
  endtask

  task automatic check_failed(input string what);
    errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  // each handshaken response against the oldest expected one
  a_fault : assert property (@(posedge clk) disable iff (rst_i)
      (resp_valid_o && resp_ready_i) |-> (resp_fault_o == exp_fault))
    else value_mismatch("resp_fault_o", 32'($sampled(resp_fault_o)), 32'($sampled(exp_fault)));
  a_attr : assert property (@(posedge clk) disable iff (rst_i)
      (resp_valid_o && resp_ready_i) |-> (resp_attr_o == exp_attr))
    else value_mismatch("resp_attr_o", 32'($sampled(resp_attr_o)), 32'($sampled(exp_attr)));
  a_dm : assert property (@(posedge clk) disable iff (rst_i)
      (resp_valid_o && resp_ready_i) |-> (resp_override_dm_o == exp_dm))
    else value_mismatch("resp_override_dm_o", 32'($sampled(resp_override_dm_o)),
                        32'($sampled(exp_dm)));
  a_region : assert property (@(posedge clk) disable iff (rst_i)
      (resp_valid_o && resp_ready_i) |-> (resp_region_o == exp_region))
    else value_mismatch("resp_region_o", 32'($sampled(resp_region_o)),
                        32'($sampled(exp_region)));
  a_have : assert property (@(posedge clk) disable iff (rst_i)
      (resp_valid_o && resp_ready_i) |-> (resp_have_match_o == exp_have))
    else value_mismatch("resp_have_match_o", 32'($sampled(resp_have_match_o)),
                        32'($sampled(exp_have)));

  // response valid exactly while an accepted transfer waits for it
  // so it rises one cycle after acceptance and never appears on its own
  a_resp_valid : assert property (@(posedge clk) disable iff (rst_i)
      resp_valid_o == exp_pending)
    else value_mismatch("resp_valid_o", 32'($sampled(resp_valid_o)),
                        32'($sampled(exp_pending)));

  // request side open when the stage is empty or its response leaves now
  a_ready : assert property (@(posedge clk) disable iff (rst_i)
      trans_ready_o == (!exp_pending || resp_ready_i))
    else value_mismatch("trans_ready_o", 32'($sampled(trans_ready_o)),
                        32'(!$sampled(exp_pending) || $sampled(resp_ready_i)));

  // a stalled response keeps valid and its whole payload
  a_stall_hold : assert property (@(posedge clk) disable iff (rst_i)
      (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_fault_o) &&
        $stable(resp_attr_o) && $stable(resp_override_dm_o) &&
        $stable(resp_region_o) && $stable(resp_have_match_o)))
    else check_failed("response changed or dropped while held by back-pressure");

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_entry(input region_idx_t idx, input cfg_field_t field,
                             input addr_t data);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = idx;
    cfg_field_i = field;
    cfg_wdata_i = data;
    next_cycle();
    cfg_we_i = 1'b0;
  endtask

  task automatic program_region(input region_idx_t idx, input addr_t base,
                                input addr_t mask, input pma_attr_t attr);
    write_entry(idx, CFG_FIELD_BASE, base);
    write_entry(idx, CFG_FIELD_MASK, mask);
    write_entry(idx, CFG_FIELD_ATTR, 32'(attr));
  endtask

  // holds the request until ready is seen high mid-cycle
  task automatic send(input addr_t addr, input logic [1:0] size, input logic load);
    logic taken;
    taken         = 1'b0;
    trans_valid_i = 1'b1;
    trans_addr_i  = addr;
    trans_size_i  = size;
    trans_load_i  = load;
    while (!taken) begin
      resp_ready_i = stall_on ? (rand_below(10) < 6) : 1'b1;
      @(negedge clk);
      taken = trans_ready_o;
      next_cycle();
    end
    trans_valid_i = 1'b0;
    xfers++;
  endtask

  task automatic idle_cycle();
    trans_valid_i = 1'b0;
    resp_ready_i  = stall_on ? (rand_below(10) < 6) : 1'b1;
    next_cycle();
  endtask

  // empties the output stage, then reports the test
  task automatic end_test(input string name);
    trans_valid_i = 1'b0;
    resp_ready_i  = 1'b1;
    while (exp_pending || resp_valid_o) next_cycle();
    next_cycle();
    $display("test %s: %0d transfers, %0d errors", name, xfers - mark_xfers,
             errors - mark_errors);
    mark_xfers  = xfers;
    mark_errors = errors;
  endtask

  initial begin
    addr_t a;
    clk           = 1'b0;
    rst_i         = 1'b1;
    cfg_we_i      = 1'b0;
    cfg_idx_i     = '0;
    cfg_field_i   = '0;
    cfg_wdata_i   = '0;
    trans_valid_i = 1'b0;
    trans_addr_i  = '0;
    trans_size_i  = '0;
    trans_load_i  = 1'b0;
    resp_ready_i  = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst_i = 1'b0;
    a_rst_valid : assert (resp_valid_o == 1'b0)
      else value_mismatch("resp_valid_o", 32'(resp_valid_o), 32'd0);
    a_rst_ready : assert (trans_ready_o == 1'b1)
      else value_mismatch("trans_ready_o", 32'(trans_ready_o), 32'd1);

    // empty table faults everywhere except the debug window
    for (int i = 0; i < 24; i++) begin
      send(lcg_next() | 32'h100, 2'(rand_below(3)), rand_below(2) == 1);
    end
    for (int i = 0; i < 8; i++) begin
      send(`PMA_DM_BASE | (lcg_next() & ~`PMA_DM_MASK), 2'd0, 1'b1);
    end
    end_test("reset and empty table");

    // nested regions at 0x8000_0000
    // lowest index is the smallest window
    program_region(2'd0, 32'h8000_0000, 32'hFFFF_F000, 4'b1001);
    program_region(2'd1, 32'h8000_0000, 32'hFFFF_0000, 4'b0111);
    program_region(2'd2, 32'h8000_0000, 32'hF000_0000, 4'b0100);
    program_region(2'd3, 32'h2000_0000, 32'hF000_0000, 4'b0001);
    for (int i = 0; i < 40; i++) begin
      send(pick_addr() & ~32'h3, 2'd2, 1'b0);
    end
    end_test("overlapping regions");

    // region 0 carries integrity, region 3 is plain main
    for (int i = 0; i < 12; i++) begin
      a = 32'h8000_0000 | (lcg_next() & 32'h0000_0FFC);
      send(a, 2'd2, 1'b1);
      send(a | 32'h1, 2'd1, 1'b1);
      send(a | 32'h2, 2'd2, 1'b0);
      send(32'h2000_0001 | (a & 32'h0000_0FFF), 2'd2, 1'b1);
    end
    end_test("misaligned integrity");

    stall_on = 1'b1;
    for (int i = 0; i < RANDOM_XFERS; i++) begin
      if (rand_below(4) == 0) begin
        idle_cycle();
      end
      send(pick_addr(), 2'(rand_below(3)), rand_below(2) == 1);
    end
    stall_on = 1'b0;
    end_test("random stalls");

    // counts accumulate from reset over all earlier tests
    a_cnt_access : assert (cnt_access_o == pma_cnt_t'(mdl_access))
      else value_mismatch("cnt_access_o", 32'(cnt_access_o), 32'(mdl_access));
    a_cnt_no_match : assert (cnt_no_match_o == pma_cnt_t'(mdl_no_match))
      else value_mismatch("cnt_no_match_o", 32'(cnt_no_match_o), 32'(mdl_no_match));
    a_cnt_multi : assert (cnt_multi_match_o == pma_cnt_t'(mdl_multi))
      else value_mismatch("cnt_multi_match_o", 32'(cnt_multi_match_o), 32'(mdl_multi));
    a_cnt_misaligned : assert (cnt_misaligned_o == pma_cnt_t'(mdl_misaligned))
      else value_mismatch("cnt_misaligned_o", 32'(cnt_misaligned_o), 32'(mdl_misaligned));
    a_cnt_load : assert (cnt_load_o == pma_cnt_t'(mdl_load))
      else value_mismatch("cnt_load_o", 32'(cnt_load_o), 32'(mdl_load));
    a_one_resp_each : assert (resp_seen == xfers && mdl_access == xfers)
      else check_failed("accepted transfers and responses differ in number");
    end_test("event counters");

    $display("summary: 5 tests, %0d transfers, %0d errors", xfers, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/pma_cfg_pkg.sv
source/pma_status_pkg.sv
source/pma_cfg_regs.sv
source/pma_region_match.sv
source/pma_access_check.sv
source/pma_event_counters.sv
source/pma_top.sv
bench/tb_pma_top.sv

// ==== source/pma_access_check.sv ====
// pma_access_check: alignment, fault decision and one-entry response stage
`timescale 1ns/10ps
`default_nettype none

module pma_access_check
  import pma_cfg_pkg::*;
#(
  parameter bit IS_INSTR_SIDE = 1'b0
)(
  input  wire logic        clk,
  input  wire logic        rst_i,

  // core request side
  input  wire logic        trans_valid_i,
  output logic             trans_ready_o,
  input  wire addr_t       trans_addr_i,
  input  wire logic [1:0]  trans_size_i,

  // lookup result for the current address
  input  wire pma_attr_t   attr_i,
  input  wire logic        override_dm_i,
  input  wire logic        have_match_i,
  input  wire region_idx_t match_idx_i,

  // registered response
  output logic             resp_valid_o,
  input  wire logic        resp_ready_i,
  output logic             resp_fault_o,
  output pma_attr_t        resp_attr_o,
  output logic             resp_override_dm_o,
  output region_idx_t      resp_region_o,
  output logic             resp_have_match_o,

  // per-transfer strobes for the counters
  output logic             misaligned_o,
  output logic             accept_o
);

  logic      fault;
  pma_attr_t side_attr;

  // size 0 is a byte and never misaligned
  always_comb begin
    case (trans_size_i)
      2'd0:    misaligned_o = 1'b0;
      2'd1:    misaligned_o = trans_addr_i[0];
      default: misaligned_o = |trans_addr_i[1:0];
    endcase
  end

  // non-main always faults
  // misaligned faults on integrity regions, and always on fetches
  assign fault = !attr_i[ATTR_MAIN] ||
                 (misaligned_o && (attr_i[ATTR_INTEGRITY] || IS_INSTR_SIDE));

  // fetches are never bufferable
  always_comb begin
    side_attr = attr_i;
    if (IS_INSTR_SIDE) begin
      side_attr[ATTR_BUFFERABLE] = 1'b0;
    end
  end

  // free when empty, or when the held response leaves this cycle
  assign trans_ready_o = !resp_valid_o || resp_ready_i;
  assign accept_o      = trans_valid_i && trans_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else if (accept_o) begin
      resp_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;
    end
  end

  // payload only moves on acceptance
  always_ff @(posedge clk) begin
    if (accept_o) begin
      resp_fault_o       <= fault;
      resp_attr_o        <= side_attr;
      resp_override_dm_o <= override_dm_i;
      resp_region_o      <= match_idx_i;
      resp_have_match_o  <= have_match_i;
    end
  end

  // a stalled response keeps its valid and its contents
  a_resp_hold : assert property (
    @(posedge clk) disable iff (rst_i)
      (resp_valid_o && !resp_ready_i)
      |=> (resp_valid_o && $stable(resp_fault_o) && $stable(resp_attr_o) &&
           $stable(resp_region_o))
  );

  if (IS_INSTR_SIDE) begin : g_instr_chk
    a_no_bufferable_fetch : assert property (
      @(posedge clk) disable iff (rst_i)
        resp_valid_o |-> !resp_attr_o[ATTR_BUFFERABLE]
    );
  end

endmodule

`default_nettype wire

// ==== source/pma_cfg_pkg.sv ====
// region table types: address, index, attribute and write-field encodings
`default_nettype none

`include "pma_consts.svh"

package pma_cfg_pkg;

  // base or mask of one table entry, same width as a bus address
  typedef logic [`PMA_ADDR_W-1:0] addr_t;

  // selects one table entry
  typedef logic [1:0] region_idx_t;

  // attribute bits, main in bit 0
  typedef logic [3:0] pma_attr_t;
  localparam int ATTR_MAIN       = 0;
  localparam int ATTR_BUFFERABLE = 1;
  localparam int ATTR_CACHEABLE  = 2;
  localparam int ATTR_INTEGRITY  = 3;

  // entry part hit by a table write
  typedef logic [1:0] cfg_field_t;
  localparam cfg_field_t CFG_FIELD_BASE = 2'd0;
  localparam cfg_field_t CFG_FIELD_MASK = 2'd1;
  localparam cfg_field_t CFG_FIELD_ATTR = 2'd2;

endpackage

`default_nettype wire

// ==== source/pma_cfg_regs.sv ====
// pma_cfg_regs: writable table of region base, mask and attribute entries
`timescale 1ns/10ps
`default_nettype none

`include "pma_consts.svh"

module pma_cfg_regs
  import pma_cfg_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_i,

  // single-cycle write port
  input  wire logic        cfg_we_i,
  input  wire region_idx_t cfg_idx_i,
  input  wire cfg_field_t  cfg_field_i,
  input  wire addr_t       cfg_wdata_i,

  // whole table, read in parallel by the matcher
  output addr_t            region_base_o [`PMA_NUM_REGIONS],
  output addr_t            region_mask_o [`PMA_NUM_REGIONS],
  output pma_attr_t        region_attr_o [`PMA_NUM_REGIONS]
);

  addr_t     base_q [`PMA_NUM_REGIONS];
  addr_t     mask_q [`PMA_NUM_REGIONS];
  pma_attr_t attr_q [`PMA_NUM_REGIONS];

  // reset leaves mask all ones, base zero and attributes clear
  // a write lands at the clock edge, so the matcher sees it next cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
        base_q[r] <= '0;
        mask_q[r] <= '1;
        attr_q[r] <= '0;
      end
    end else if (cfg_we_i) begin
      case (cfg_field_i)
        CFG_FIELD_BASE: base_q[cfg_idx_i] <= cfg_wdata_i;
        CFG_FIELD_MASK: mask_q[cfg_idx_i] <= cfg_wdata_i;
        // attributes live in the low bits of the write data
        CFG_FIELD_ATTR: attr_q[cfg_idx_i] <= cfg_wdata_i[$bits(pma_attr_t)-1:0];
        default: ;
      endcase
    end
  end

  assign region_base_o = base_q;
  assign region_mask_o = mask_q;
  assign region_attr_o = attr_q;

  // an attribute write must not disturb the address part of its entry
  for (genvar g = 0; g < `PMA_NUM_REGIONS; g++) begin : g_attr_chk
    a_attr_write_keeps_addr : assert property (
      @(posedge clk) disable iff (rst_i)
        (cfg_we_i && cfg_field_i == CFG_FIELD_ATTR && cfg_idx_i == region_idx_t'(g))
        |=> ($stable(region_base_o[g]) && $stable(region_mask_o[g]))
    );
  end

endmodule

`default_nettype wire

// ==== source/pma_consts.svh ====
// region count, address width, debug-module window and counter width macros
`ifndef PMA_CONSTS_SVH
`define PMA_CONSTS_SVH

// number of entries in the region table
// a two-bit region index covers all of them
`define PMA_NUM_REGIONS 4

// width of transfer addresses, bases and masks
`define PMA_ADDR_W 32

// debug-module window, always treated as main memory
// 2 KiB block, compared under the mask below
`define PMA_DM_BASE 32'h1A11_0800
`define PMA_DM_MASK 32'hFFFF_F800

// width of each saturating event counter
`define PMA_CNT_W 16

`endif

// ==== source/pma_event_counters.sv ====
// pma_event_counters: saturating counts of accepted transfers by match class
`timescale 1ns/10ps
`default_nettype none

`include "pma_consts.svh"

module pma_event_counters
  import pma_status_pkg::*;
#(
  parameter bit IS_INSTR_SIDE = 1'b0
)(
  input  wire logic        clk,
  input  wire logic        rst_i,

  // sampled in the acceptance cycle
  input  wire logic        accept_i,
  input  wire match_list_t match_list_i,
  input  wire logic        have_match_i,
  input  wire logic        misaligned_i,
  input  wire logic        load_i,

  output pma_cnt_t         cnt_access_o,
  output pma_cnt_t         cnt_no_match_o,
  output pma_cnt_t         cnt_multi_match_o,
  output pma_cnt_t         cnt_misaligned_o,
  output pma_cnt_t         cnt_load_o
);

  num_match_t num_match;
  logic       is_load;

  // sticks at the top value instead of wrapping
  function automatic pma_cnt_t sat_inc(input pma_cnt_t v);
    return (v == CNT_MAX) ? v : v + pma_cnt_t'(1);
  endfunction

  // population count of the match vector
  always_comb begin
    num_match = '0;
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      num_match = num_match + num_match_t'(match_list_i[r]);
    end
  end

  // loads only mean something on the data side
  assign is_load = !IS_INSTR_SIDE && load_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_access_o      <= '0;
      cnt_no_match_o    <= '0;
      cnt_multi_match_o <= '0;
      cnt_misaligned_o  <= '0;
      cnt_load_o        <= '0;
    end else if (accept_i) begin
      cnt_access_o <= sat_inc(cnt_access_o);
      if (!have_match_i)                  cnt_no_match_o    <= sat_inc(cnt_no_match_o);
      if (num_match >= MULTI_MATCH_MIN)   cnt_multi_match_o <= sat_inc(cnt_multi_match_o);
      if (misaligned_i)                   cnt_misaligned_o  <= sat_inc(cnt_misaligned_o);
      if (is_load)                        cnt_load_o        <= sat_inc(cnt_load_o);
    end
  end

  // match count is bounded, and agrees with the matcher's own flag
  a_num_match_bound : assert property (
    @(posedge clk) disable iff (rst_i)
      accept_i |-> ((num_match <= num_match_t'(`PMA_NUM_REGIONS)) &&
                    (have_match_i == (num_match != '0)))
  );

endmodule

`default_nettype wire

// ==== source/pma_region_match.sv ====
// pma_region_match: parallel region compare with lowest-index priority select
`timescale 1ns/10ps
`default_nettype none

`include "pma_consts.svh"

module pma_region_match
  import pma_cfg_pkg::*, pma_status_pkg::*;
(
  input  wire addr_t       trans_addr_i,

  input  wire addr_t       region_base_i [`PMA_NUM_REGIONS],
  input  wire addr_t       region_mask_i [`PMA_NUM_REGIONS],
  input  wire pma_attr_t   region_attr_i [`PMA_NUM_REGIONS],

  output match_list_t      match_list_o,
  output logic             have_match_o,
  output region_idx_t      match_idx_o,
  output pma_attr_t        attr_o,
  output logic             override_dm_o
);

  logic      in_dm_window;
  pma_attr_t sel_attr;

  // every entry compared at once, masked address against masked base
  always_comb begin
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      match_list_o[r] = ((trans_addr_i & region_mask_i[r]) ==
                         (region_base_i[r] & region_mask_i[r]));
    end
  end

  // priority encoder, walks down so the lowest set index wins
  // index stays zero when nothing matches
  always_comb begin
    match_idx_o  = '0;
    have_match_o = 1'b0;
    for (int r = `PMA_NUM_REGIONS - 1; r >= 0; r--) begin
      if (match_list_o[r]) begin
        match_idx_o  = region_idx_t'(r);
        have_match_o = 1'b1;
      end
    end
  end

  // no match reads as all-zero attributes, i.e. non-main
  assign sel_attr = have_match_o ? region_attr_i[match_idx_o] : '0;

  // debug-module window overrides whatever the table says
  assign in_dm_window = ((trans_addr_i & `PMA_DM_MASK) ==
                         (`PMA_DM_BASE & `PMA_DM_MASK));

  always_comb begin
    attr_o = sel_attr;
    if (in_dm_window) begin
      attr_o[ATTR_MAIN] = 1'b1;
    end
  end

  assign override_dm_o = in_dm_window;

  // encoder found flag must agree with the raw compare vector
  always_comb begin
    a_have_match_consistent : assert (have_match_o == (|match_list_o));
  end

endmodule

`default_nettype wire

// ==== source/pma_status_pkg.sv ====
// match status and event count types
`default_nettype none

`include "pma_consts.svh"

package pma_status_pkg;

  // one bit per region, bit r set when region r matches
  typedef logic [`PMA_NUM_REGIONS-1:0] match_list_t;

  // number of set bits in a match list
  // three bits hold 0 up to 4 regions
  typedef logic [2:0] num_match_t;

  // one saturating event count
  typedef logic [`PMA_CNT_W-1:0] pma_cnt_t;

  // threshold for an overlapping hit
  localparam num_match_t MULTI_MATCH_MIN = 3'd2;

  // largest value a counter reaches before it sticks
  localparam pma_cnt_t CNT_MAX = '1;

endpackage

`default_nettype wire

// ==== source/pma_top.sv ====
// pma_top: region table, matcher, access checker and event counters
`timescale 1ns/10ps
`default_nettype none

`include "pma_consts.svh"

module pma_top
  import pma_cfg_pkg::*, pma_status_pkg::*;
#(
  parameter bit IS_INSTR_SIDE = 1'b0
)(
  input  wire logic        clk,
  input  wire logic        rst_i,

  // region table write port
  input  wire logic        cfg_we_i,
  input  wire region_idx_t cfg_idx_i,
  input  wire cfg_field_t  cfg_field_i,
  input  wire addr_t       cfg_wdata_i,

  // transfer request
  input  wire logic        trans_valid_i,
  output logic             trans_ready_o,
  input  wire addr_t       trans_addr_i,
  input  wire logic [1:0]  trans_size_i,
  input  wire logic        trans_load_i,

  // response
  output logic             resp_valid_o,
  input  wire logic        resp_ready_i,
  output logic             resp_fault_o,
  output pma_attr_t        resp_attr_o,
  output logic             resp_override_dm_o,
  output region_idx_t      resp_region_o,
  output logic             resp_have_match_o,

  // event counters
  output pma_cnt_t         cnt_access_o,
  output pma_cnt_t         cnt_no_match_o,
  output pma_cnt_t         cnt_multi_match_o,
  output pma_cnt_t         cnt_misaligned_o,
  output pma_cnt_t         cnt_load_o
);

  addr_t       region_base [`PMA_NUM_REGIONS];
  addr_t       region_mask [`PMA_NUM_REGIONS];
  pma_attr_t   region_attr [`PMA_NUM_REGIONS];

  // combinational lookup of the current address
  match_list_t match_list;
  logic        have_match;
  region_idx_t match_idx;
  pma_attr_t   match_attr;
  logic        override_dm;

  // strobes from checker to counters
  logic        accept;
  logic        misaligned;

  pma_cfg_regs u_cfg_regs (
    .clk           (clk),
    .rst_i         (rst_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_field_i   (cfg_field_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .region_base_o (region_base),
    .region_mask_o (region_mask),
    .region_attr_o (region_attr)
  );

  pma_region_match u_region_match (
    .trans_addr_i  (trans_addr_i),
    .region_base_i (region_base),
    .region_mask_i (region_mask),
    .region_attr_i (region_attr),
    .match_list_o  (match_list),
    .have_match_o  (have_match),
    .match_idx_o   (match_idx),
    .attr_o        (match_attr),
    .override_dm_o (override_dm)
  );

  pma_access_check #(
    .IS_INSTR_SIDE (IS_INSTR_SIDE)
  ) u_access_check (
    .clk                (clk),
    .rst_i              (rst_i),
    .trans_valid_i      (trans_valid_i),
    .trans_ready_o      (trans_ready_o),
    .trans_addr_i       (trans_addr_i),
    .trans_size_i       (trans_size_i),
    .attr_i             (match_attr),
    .override_dm_i      (override_dm),
    .have_match_i       (have_match),
    .match_idx_i        (match_idx),
    .resp_valid_o       (resp_valid_o),
    .resp_ready_i       (resp_ready_i),
    .resp_fault_o       (resp_fault_o),
    .resp_attr_o        (resp_attr_o),
    .resp_override_dm_o (resp_override_dm_o),
    .resp_region_o      (resp_region_o),
    .resp_have_match_o  (resp_have_match_o),
    .misaligned_o       (misaligned),
    .accept_o           (accept)
  );

  pma_event_counters #(
    .IS_INSTR_SIDE (IS_INSTR_SIDE)
  ) u_event_counters (
    .clk               (clk),
    .rst_i             (rst_i),
    .accept_i          (accept),
    .match_list_i      (match_list),
    .have_match_i      (have_match),
    .misaligned_i      (misaligned),
    .load_i            (trans_load_i),
    .cnt_access_o      (cnt_access_o),
    .cnt_no_match_o    (cnt_no_match_o),
    .cnt_multi_match_o (cnt_multi_match_o),
    .cnt_misaligned_o  (cnt_misaligned_o),
    .cnt_load_o        (cnt_load_o)
  );

endmodule

`default_nettype wire
